/* Bender.yml */
package:
  name: lb_exerciser

sources:
  - design/lb_pkg.sv
  - design/lb_csr_regs.sv
  - design/lb_test_sequencer.sv
  - design/lb_status_writer.sv
  - design/lb_traffic_stats.sv
  - design/lb_exerciser_top.sv
  - target: test
    files:
      - tests/lb_exerciser_assertions.sv
      - tests/tb_lb_exerciser.sv

/* design/lb_csr_regs.sv */
/* Control and status registers. Read data is registered and valid one cycle
   after csr_rd; only the low 32 bits of the 40-bit counters are visible. */
`timescale 1ns/1ps
`default_nettype none

module lb_csr_regs
    import lb_pkg::*;
(
    input  logic        clk,
    input  logic        test_rst_n,
    input  logic        csr_wr,
    input  logic        csr_rd,
    input  t_csr_addr   csr_addr,
    input  t_csr_data   csr_wdata,
    output t_csr_data   csr_rdata,
    input  t_stats      stats,
    input  logic        test_active,
    output logic        soft_rst_n,
    output logic        start,
    output t_lb_cfg     cfg,
    output t_line_addr  dsm_base,
    output logic [15:0] intr_vec
);

    // ============================================================
    // Writable registers
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!test_rst_n)
        begin
            // Soft reset is released by default
            soft_rst_n <= 1'b1;
            start      <= 1'b0;
            cfg        <= '0;
            dsm_base   <= '0;
            intr_vec   <= '0;
        end
        else if (csr_wr)
        begin
            case (csr_addr)
                CSR_CTL:
                begin
                    soft_rst_n <= csr_wdata[0];
                    start      <= csr_wdata[1];
                end
                CSR_CFG:
                begin
                    cfg.test_mode    <= csr_wdata[0];
                    cfg.atomic_en    <= csr_wdata[1];
                    cfg.intr_on_done <= csr_wdata[2];
                end
                CSR_DSM_BASE: dsm_base <= csr_wdata;
                // Vector sits in the upper half
                CSR_INTR: intr_vec <= csr_wdata[31:16];
                default: ;
            endcase
        end
    end

    // ============================================================
    // Registered readback
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (csr_rd)
        begin
            case (csr_addr)
                CSR_CTL:        csr_rdata <= {30'h0, start, soft_rst_n};
                CSR_CFG:        csr_rdata <= {29'h0, cfg.intr_on_done, cfg.atomic_en,
                                              cfg.test_mode};
                CSR_DSM_BASE:   csr_rdata <= dsm_base;
                CSR_INTR:       csr_rdata <= {intr_vec, 16'h0};
                CSR_NUM_READS:  csr_rdata <= stats.num_reads[31:0];
                CSR_NUM_WRITES: csr_rdata <= stats.num_writes[31:0];
                // Writes pending in the high half
                CSR_PENDING:    csr_rdata <= {stats.wr_pend, stats.rd_pend};
                CSR_STATUS:     csr_rdata <= {31'h0, test_active};
                // Unmapped words
                default:        csr_rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/lb_exerciser_top.sv */
/* Test controller top level. Engines sit outside and hook up via start,
   select and done; mon is a passive copy of the host bus. */
`timescale 1ns/1ps
`default_nettype none

module lb_exerciser_top
    import lb_pkg::*;
#(
    parameter int PEND_W = 16
)
(
    input  logic                   clk,
    input  logic                   test_rst_n,
    input  logic                   csr_wr,
    input  logic                   csr_rd,
    input  t_csr_addr              csr_addr,
    input  t_csr_data              csr_wdata,
    output t_csr_data              csr_rdata,
    output logic                   eng_start,
    output t_eng_sel               eng_sel,
    input  logic [NUM_ENGINES-1:0] eng_done,
    output logic                   wr_valid,
    output t_mem_wr_req            wr_req,
    input  logic                   wr_ready,
    input  t_mem_mon               mon
);

    // ============================================================
    // Internal nets
    // ============================================================

    logic        soft_rst_n;
    logic        start;
    t_lb_cfg     cfg;
    t_line_addr  dsm_base;
    logic [15:0] intr_vec;
    t_stats      stats;
    logic        test_active;
    logic        test_end;
    logic        report_done;
    t_count      cycles;

    lb_csr_regs lb_csr_regs_inst (
        .clk, .test_rst_n, .csr_wr, .csr_rd, .csr_addr, .csr_wdata, .csr_rdata,
        .stats, .test_active, .soft_rst_n, .start, .cfg, .dsm_base, .intr_vec
    );

    // Start handling and run control
    lb_test_sequencer lb_test_sequencer_inst (
        .clk, .test_rst_n, .soft_rst_n, .start, .cfg, .eng_done, .report_done,
        .eng_start, .test_active, .test_end, .eng_sel, .cycles
    );

    // Status and interrupt writes toward the host
    lb_status_writer lb_status_writer_inst (
        .clk, .test_rst_n, .soft_rst_n, .test_end, .cfg, .dsm_base, .intr_vec,
        .cycles, .stats, .wr_valid, .wr_req, .wr_ready, .report_done
    );

    // Counters keep running during back-pressure
    lb_traffic_stats #(
        .PEND_W (PEND_W)
    ) lb_traffic_stats_inst (
        .clk, .test_rst_n, .soft_rst_n, .mon, .stats
    );

endmodule

`default_nettype wire

/* design/lb_pkg.sv */
/* Shared types for the loopback exerciser test controller.
   The status record layout fixes all widths except the in-flight counter width. */
`default_nettype none

package lb_pkg;

    // Register file words
    typedef logic [3:0]   t_csr_addr;
    typedef logic [31:0]  t_csr_data;

    // Event and cycle counters share one width
    typedef logic [39:0]  t_count;

    // Host addressing, 64 byte lines
    typedef logic [31:0]  t_line_addr;
    typedef logic [37:0]  t_byte_addr;
    typedef logic [14:0]  t_uid;
    typedef logic [255:0] t_line;

    localparam int NUM_ENGINES = 3;

    typedef enum logic [1:0] {ENG_LPBK = 2'd0, ENG_ATOMIC = 2'd1, ENG_RDWR = 2'd2} t_eng_sel;
    typedef enum logic [1:0] {SEQ_IDLE, SEQ_RUN, SEQ_REPORT} t_seq_state;
    typedef enum logic [1:0] {WR_IDLE, WR_STATUS, WR_INTR} t_wr_state;

    typedef struct packed {
        logic test_mode;
        logic atomic_en;
        logic intr_on_done;
    } t_lb_cfg;

    typedef struct packed {
        t_byte_addr addr;
        t_line      data;
        logic       is_intr;
    } t_mem_wr_req;

    // One bit per monitored host bus event
    typedef struct packed {
        logic rd_req;
        logic rd_beat;
        logic rd_last;
        logic wr_req;
        logic wr_beat;
        logic wr_resp;
    } t_mem_mon;

    typedef struct packed {
        t_count      num_reads;
        t_count      num_writes;
        logic [15:0] rd_pend;
        logic [15:0] wr_pend;
    } t_stats;

    // CSR word indices
    localparam t_csr_addr CSR_CTL        = 4'd0;
    localparam t_csr_addr CSR_CFG        = 4'd1;
    localparam t_csr_addr CSR_DSM_BASE   = 4'd2;
    localparam t_csr_addr CSR_INTR       = 4'd3;
    localparam t_csr_addr CSR_NUM_READS  = 4'd4;
    localparam t_csr_addr CSR_NUM_WRITES = 4'd5;
    localparam t_csr_addr CSR_PENDING    = 4'd6;
    localparam t_csr_addr CSR_STATUS     = 4'd7;

endpackage

`default_nettype wire

/* design/lb_status_writer.sv */
/* Status record and interrupt writes after a test. Request fields are held
   while wr_valid waits for wr_ready; the uid survives a soft reset. */
`timescale 1ns/1ps
`default_nettype none

module lb_status_writer
    import lb_pkg::*;
(
    input  logic        clk,
    input  logic        test_rst_n,
    input  logic        soft_rst_n,
    input  logic        test_end,
    input  t_lb_cfg     cfg,
    input  t_line_addr  dsm_base,
    input  logic [15:0] intr_vec,
    input  t_count      cycles,
    input  t_stats      stats,
    output logic        wr_valid,
    output t_mem_wr_req wr_req,
    input  logic        wr_ready,
    output logic        report_done
);

    logic       run_rst_n;
    logic       accept;
    t_wr_state  state;
    t_uid       uid;
    t_line      rec;
    t_byte_addr status_addr;
    t_byte_addr intr_addr;
    logic       intr_en;

    assign run_rst_n = test_rst_n & soft_rst_n;
    assign accept    = wr_valid && wr_ready;

    // ============================================================
    // Snapshot taken at test end
    // ============================================================

    always_ff @(posedge clk)
    begin
        if ((state == WR_IDLE) && test_end)
        begin
            // Flag, uid, cycles and both 40-bit counts split in two
            rec <= {64'h0, stats.num_writes[31:0], stats.num_reads[31:0],
                    stats.num_writes[39:32], stats.num_reads[39:32],
                    8'h0, cycles, 48'h0, uid, 1'b1};
            status_addr <= {dsm_base, 6'h0};
            intr_addr   <= t_byte_addr'(intr_vec);
            intr_en     <= cfg.intr_on_done;
        end
    end

    // ============================================================
    // Write sequencing
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!run_rst_n)
        begin
            state       <= WR_IDLE;
            wr_valid    <= 1'b0;
            report_done <= 1'b0;
        end
        else
        begin
            report_done <= 1'b0;
            case (state)
                WR_IDLE: if (test_end) state <= WR_STATUS;
                WR_STATUS, WR_INTR:
                begin
                    // One issue cycle before each request
                    if (!wr_valid)
                        wr_valid <= 1'b1;
                    else if (wr_ready)
                    begin
                        wr_valid <= 1'b0;
                        if ((state == WR_STATUS) && intr_en)
                            state <= WR_INTR;
                        else
                        begin
                            state       <= WR_IDLE;
                            report_done <= 1'b1;
                        end
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // Same payload for both writes
    assign wr_req.addr    = (state == WR_INTR) ? intr_addr : status_addr;
    assign wr_req.data    = rec;
    assign wr_req.is_intr = (state == WR_INTR);

    // Sequence number, one step per accepted write
    always_ff @(posedge clk)
    begin
        if (!test_rst_n)
            uid <= '0;
        else if (accept)
            uid <= uid + 1'b1;
    end

endmodule

`default_nettype wire

/* design/lb_test_sequencer.sv */
/* Start edge detection and test state machine. A start seen outside idle is
   dropped; the cycle counter restarts on each engine start. */
`timescale 1ns/1ps
`default_nettype none

module lb_test_sequencer
    import lb_pkg::*;
(
    input  logic                   clk,
    input  logic                   test_rst_n,
    input  logic                   soft_rst_n,
    input  logic                   start,
    input  t_lb_cfg                cfg,
    input  logic [NUM_ENGINES-1:0] eng_done,
    input  logic                   report_done,
    output logic                   eng_start,
    output logic                   test_active,
    output logic                   test_end,
    output t_eng_sel               eng_sel,
    output t_count                 cycles
);

    // Either reset source stops the test
    logic       run_rst_n;
    logic       start_q;
    logic       sel_done;
    t_seq_state state;

    assign run_rst_n = test_rst_n & soft_rst_n;

    // ============================================================
    // Start edge and engine choice
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!run_rst_n)
        begin
            start_q <= 1'b0;
        end
        else
        begin
            start_q <= start;
        end
    end

    // Rising edge of start, only accepted when idle
    assign eng_start = start && !start_q && (state == SEQ_IDLE);

    // Atomic mode wins over test_mode
    always_ff @(posedge clk)
    begin
        if (!run_rst_n)
            eng_sel <= ENG_LPBK;
        else if (cfg.atomic_en)
            eng_sel <= ENG_ATOMIC;
        else if (!cfg.test_mode)
            eng_sel <= ENG_LPBK;
        else
            eng_sel <= ENG_RDWR;
    end

    // Only the selected engine's done counts
    assign sel_done = eng_done[eng_sel];

    // ============================================================
    // Test state machine
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!run_rst_n)
        begin
            state    <= SEQ_IDLE;
            test_end <= 1'b0;
        end
        else
        begin
            // One cycle pulse toward the status writer
            test_end <= (state == SEQ_RUN) && sel_done;
            case (state)
                SEQ_IDLE:   if (eng_start) state <= SEQ_RUN;
                SEQ_RUN:    if (sel_done) state <= SEQ_REPORT;
                // Wait for the last host write to be taken
                SEQ_REPORT: if (report_done) state <= SEQ_IDLE;
                default:    state <= SEQ_IDLE;
            endcase
        end
    end

    assign test_active = (state == SEQ_RUN);

    // Cycle counter, frozen outside the run state
    always_ff @(posedge clk)
    begin
        if (!run_rst_n || eng_start)
            cycles <= '0;
        else if (test_active)
            cycles <= cycles + 1'b1;
    end

endmodule

`default_nettype wire

/* design/lb_traffic_stats.sv */
/* Beat and in-flight counters from the host bus monitor. In-flight counts
   wrap at PEND_W bits and are reported in 16-bit fields. */
`timescale 1ns/1ps
`default_nettype none

module lb_traffic_stats
    import lb_pkg::*;
#(
    parameter int PEND_W = 16
)
(
    input  logic     clk,
    input  logic     test_rst_n,
    input  logic     soft_rst_n,
    input  t_mem_mon mon,
    output t_stats   stats
);

    logic              cnt_rst_n;
    logic              rd_done;
    t_count            num_reads;
    t_count            num_writes;
    logic [PEND_W-1:0] rd_pend;
    logic [PEND_W-1:0] wr_pend;

    assign cnt_rst_n = test_rst_n & soft_rst_n;

    // A read burst closes on its last beat
    assign rd_done = mon.rd_beat && mon.rd_last;

    // ============================================================
    // Counters
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!cnt_rst_n)
        begin
            num_reads  <= '0;
            num_writes <= '0;
            rd_pend    <= '0;
            wr_pend    <= '0;
        end
        else
        begin
            // One count per data beat
            if (mon.rd_beat)
                num_reads <= num_reads + 1'b1;
            if (mon.wr_beat)
                num_writes <= num_writes + 1'b1;

            // Request and completion together leave the count alone
            case ({mon.rd_req, rd_done})
                2'b10:   rd_pend <= rd_pend + 1'b1;
                2'b01:   rd_pend <= rd_pend - 1'b1;
                default: rd_pend <= rd_pend;
            endcase

            // Writes close on the response
            case ({mon.wr_req, mon.wr_resp})
                2'b10:   wr_pend <= wr_pend + 1'b1;
                2'b01:   wr_pend <= wr_pend - 1'b1;
                default: wr_pend <= wr_pend;
            endcase
        end
    end

    always_comb
    begin
        stats.num_reads  = num_reads;
        stats.num_writes = num_writes;
        stats.rd_pend    = 16'(rd_pend);
        stats.wr_pend    = 16'(wr_pend);
    end

endmodule

`default_nettype wire

/* tests/lb_exerciser_assertions.sv */
/* Concurrent checks bound into the exerciser top level. Checks are disabled
   during test_rst_n; a soft reset during a pending write is not covered. */
`timescale 1ns/1ps
`default_nettype none

module lb_exerciser_assertions
    import lb_pkg::*;
(
    input logic        clk,
    input logic        test_rst_n,
    input logic        eng_start,
    input logic        test_active,
    input logic        wr_valid,
    input logic        wr_ready,
    input t_mem_wr_req wr_req
);

    // Count of assertion failures
    int fail_count = 0;

    // A stalled request keeps valid and its payload
    wr_req_held: assert property (@(posedge clk) disable iff (!test_rst_n)
        (wr_valid && !wr_ready) |=> (wr_valid && $stable(wr_req)))
        else
        begin
            $error("wr_req changed while wr_valid waited for wr_ready");
            fail_count++;
        end

    // Engine start is a single cycle pulse
    eng_start_pulse: assert property (@(posedge clk) disable iff (!test_rst_n)
        eng_start |=> !eng_start)
        else
        begin
            $error("eng_start stayed high for more than one cycle");
            fail_count++;
        end

    // No host write while the engine runs
    no_write_in_run: assert property (@(posedge clk) disable iff (!test_rst_n)
        test_active |-> !wr_valid)
        else
        begin
            $error("wr_valid high while test_active");
            fail_count++;
        end

endmodule

bind lb_exerciser_top lb_exerciser_assertions lb_exerciser_assertions_inst (
    .clk         (clk),
    .test_rst_n  (test_rst_n),
    .eng_start   (eng_start),
    .test_active (test_active),
    .wr_valid    (wr_valid),
    .wr_ready    (wr_ready),
    .wr_req      (wr_req)
);

`default_nettype wire

/* tests/lb_stim.txt */
// id cfg dsm_base intr delay rd_beats wr_beats stalls, all hex
// cfg bit0 test_mode, bit1 atomic_en, bit2 intr_on_done, bit4 soft reset first
01 00 00001000 0000 0c 05 03 00
02 04 00002000 0040 0a 04 04 00
03 04 0abcd000 1234 09 06 02 08
04 03 00003000 0000 08 03 02 03
05 01 00004000 0000 07 02 05 00
06 14 00005000 00ff 06 01 01 04
07 12 00006000 0000 05 02 02 02
08 16 00007000 0a00 0a 03 04 06

/* tests/tb_lb_exerciser.sv */
/* Testbench for the exerciser top level, driven from tests/lb_stim.txt.
   Engine delay must be at least 1 and at least both beat counts. */
`timescale 1ns/1ps
`default_nettype none

module tb_lb_exerciser
    import lb_pkg::*;
();

    localparam int STIM_COLS     = 8;
    localparam int MAX_TESTS     = 16;
    localparam int START_TIMEOUT = 20;
    localparam int WRITE_TIMEOUT = 200;

    logic                   clk;
    logic                   test_rst_n;
    logic                   csr_wr;
    logic                   csr_rd;
    t_csr_addr              csr_addr;
    t_csr_data              csr_wdata;
    t_csr_data              csr_rdata;
    logic                   eng_start;
    t_eng_sel               eng_sel;
    logic [NUM_ENGINES-1:0] eng_done;
    logic                   wr_valid;
    t_mem_wr_req            wr_req;
    logic                   wr_ready;
    t_mem_mon               mon;

    logic [31:0] stim_mem [0:STIM_COLS*MAX_TESTS-1];
    t_mem_wr_req wr_q [$];
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          stalls_left;
    bit          aborted;

    // Reference model state
    t_count      exp_reads;
    t_count      exp_writes;
    logic [15:0] exp_rd_pend;
    logic [15:0] exp_wr_pend;
    t_uid        exp_uid;

    lb_exerciser_top #(
        .PEND_W (16)
    ) lb_exerciser_top_inst (
        .clk, .test_rst_n, .csr_wr, .csr_rd, .csr_addr, .csr_wdata, .csr_rdata,
        .eng_start, .eng_sel, .eng_done, .wr_valid, .wr_req, .wr_ready, .mon
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ============================================================
    // Host side: random wr_ready stalls and write capture
    // ============================================================

    initial
    begin
        void'($urandom(32'hb));
        wr_ready = 1'b1;
        forever
        begin
            @(negedge clk);
            // Stall budget is spent only while a write is offered
            if (wr_valid && (stalls_left > 0) && (($urandom % 2) == 1))
            begin
                wr_ready = 1'b0;
                stalls_left--;
            end
            else
                wr_ready = 1'b1;
        end
    end

    always @(posedge clk)
    begin
        if (test_rst_n && wr_valid && wr_ready)
            wr_q.push_back(wr_req);
    end

    // ============================================================
    // Helpers
    // ============================================================

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("error %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic csr_write(input t_csr_addr addr, input t_csr_data data);
        csr_wr    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        @(negedge clk);
        csr_wr = 1'b0;
    endtask

    task automatic check_csr(input t_csr_addr addr, input t_csr_data exp, input string what);
        csr_rd   = 1'b1;
        csr_addr = addr;
        @(negedge clk);
        csr_rd = 1'b0;
        check_value(what, csr_rdata, exp);
    endtask

    // Engine choice as given by the configuration rules
    function automatic t_eng_sel expected_engine(input logic [2:0] c);
        if (c[1])
            return ENG_ATOMIC;
        else if (!c[0])
            return ENG_LPBK;
        else
            return ENG_RDWR;
    endfunction

    task automatic wait_eng_start();
        int n;
        n = 0;
        while (!eng_start && (n < START_TIMEOUT))
        begin
            @(negedge clk);
            n++;
        end
        if (!eng_start)
        begin
            $display("timeout: eng_start never rose after the start write");
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_writes(input int count);
        int n;
        n = 0;
        while ((wr_q.size() < count) && (n < WRITE_TIMEOUT))
        begin
            @(negedge clk);
            n++;
        end
        if (wr_q.size() < count)
        begin
            $display("timeout: only %0d of %0d host writes arrived", wr_q.size(), count);
            errors++;
            aborted = 1'b1;
        end
    endtask

    // Beats from cycle 0, done after delay cycles; atomic requests never complete
    task automatic drive_engine(input int delay, input int rd, input int wr,
                                input bit atomic, input t_eng_sel eng);
        for (int i = 0; i < delay; i++)
        begin
            mon         = '0;
            mon.rd_beat = (i < rd);
            mon.wr_beat = (i < wr);
            if (atomic)
            begin
                mon.rd_req = (i < rd);
                mon.wr_req = (i < wr);
            end
            else
            begin
                mon.rd_req  = (i == 0) && (rd > 0);
                mon.rd_last = (i == rd - 1);
                mon.wr_req  = (i == 0) && (wr > 0);
            end
            @(negedge clk);
        end
        mon                = '0;
        mon.wr_resp        = !atomic && (wr > 0);
        eng_done[int'(eng)] = 1'b1;
        @(negedge clk);
        mon      = '0;
        eng_done = '0;
    endtask

    task automatic check_record(input t_line data, input t_uid uid, input int delay);
        t_line rest;
        int    cyc;
        rest          = data;
        rest[15:0]    = '0;
        rest[103:64]  = '0;
        rest[191:112] = '0;
        cyc           = int'(data[103:64]);
        check_value("record flag", data[0], 1'b1);
        check_value("record uid", data[15:1], uid);
        check_value("record read count high", data[119:112], exp_reads[39:32]);
        check_value("record write count high", data[127:120], exp_writes[39:32]);
        check_value("record read count low", data[159:128], exp_reads[31:0]);
        check_value("record write count low", data[191:160], exp_writes[31:0]);
        if ((cyc < delay - 2) || (cyc > delay + 2))
        begin
            $display("error %0t: record cycles %0d not within 2 of %0d", $time, cyc, delay);
            errors++;
        end
        if (rest !== '0)
        begin
            $display("error %0t: record has bits set outside its fields", $time);
            errors++;
        end
    endtask

    // ============================================================
    // Tests
    // ============================================================

    task automatic csr_access_test();
        int errors_before;
        errors_before = errors;
        tests_run++;
        csr_write(CSR_CFG, 32'h5);
        csr_write(CSR_DSM_BASE, 32'h1234_5678);
        csr_write(CSR_INTR, 32'hbeef_0000);
        check_csr(CSR_CFG, 32'h5, "CSR_CFG readback");
        check_csr(CSR_DSM_BASE, 32'h1234_5678, "CSR_DSM_BASE readback");
        check_csr(CSR_INTR, 32'hbeef_0000, "CSR_INTR readback");
        check_csr(CSR_STATUS, 32'h0, "CSR_STATUS when idle");
        check_csr(4'hc, 32'h0, "unmapped CSR");
        if (errors == errors_before)
            $display("test csr access passed");
        else
        begin
            tests_failed++;
            $display("test csr access failed");
        end
    endtask

    task automatic run_test(input int t);
        logic [31:0] id;
        logic [4:0]  cfg_word;
        t_line_addr  base;
        logic [15:0] vec;
        int          delay;
        int          rd;
        int          wr;
        int          n_writes;
        int          errors_before;
        t_eng_sel    eng;
        t_mem_wr_req w0;
        t_mem_wr_req w1;
        id            = stim_mem[t*STIM_COLS];
        cfg_word      = stim_mem[t*STIM_COLS+1][4:0];
        base          = stim_mem[t*STIM_COLS+2];
        vec           = stim_mem[t*STIM_COLS+3][15:0];
        delay         = int'(stim_mem[t*STIM_COLS+4]);
        rd            = int'(stim_mem[t*STIM_COLS+5]);
        wr            = int'(stim_mem[t*STIM_COLS+6]);
        eng           = expected_engine(cfg_word[2:0]);
        n_writes      = cfg_word[2] ? 2 : 1;
        errors_before = errors;
        tests_run++;

        // Soft reset clears counters but not the uid
        if (cfg_word[4])
        begin
            csr_write(CSR_CTL, 32'h0);
            csr_write(CSR_CTL, 32'h1);
            exp_reads   = '0;
            exp_writes  = '0;
            exp_rd_pend = '0;
            exp_wr_pend = '0;
        end
        csr_write(CSR_CFG, {29'h0, cfg_word[2:0]});
        csr_write(CSR_DSM_BASE, base);
        csr_write(CSR_INTR, {vec, 16'h0});
        csr_write(CSR_CTL, 32'h1);
        wr_q.delete();
        stalls_left = int'(stim_mem[t*STIM_COLS+7]);

        // Rising start bit launches the engine
        csr_write(CSR_CTL, 32'h3);
        wait_eng_start();
        if (aborted)
        begin
            tests_failed++;
            $display("test %0d stopped by a timeout", id);
            return;
        end
        check_value("eng_sel at eng_start", eng_sel, eng);
        drive_engine(delay, rd, wr, eng == ENG_ATOMIC, eng);
        exp_reads  = exp_reads + t_count'(rd);
        exp_writes = exp_writes + t_count'(wr);
        if (eng == ENG_ATOMIC)
        begin
            exp_rd_pend = exp_rd_pend + 16'(rd);
            exp_wr_pend = exp_wr_pend + 16'(wr);
        end

        wait_writes(n_writes);
        if (aborted)
        begin
            tests_failed++;
            $display("test %0d stopped by a timeout", id);
            return;
        end
        w0 = wr_q[0];
        check_value("status write address", w0.addr, {base, 6'h0});
        check_value("status write is_intr", w0.is_intr, 1'b0);
        check_record(w0.data, exp_uid, delay);
        if (n_writes == 2)
        begin
            w1 = wr_q[1];
            check_value("interrupt write address", w1.addr, 38'(vec));
            check_value("interrupt write is_intr", w1.is_intr, 1'b1);
            if (w1.data !== w0.data)
            begin
                $display("error %0t: interrupt write data differs from status", $time);
                errors++;
            end
        end
        exp_uid = exp_uid + t_uid'(n_writes);

        // Readback also gives the writer time to go idle
        check_csr(CSR_NUM_READS, exp_reads[31:0], "CSR_NUM_READS");
        check_csr(CSR_NUM_WRITES, exp_writes[31:0], "CSR_NUM_WRITES");
        check_csr(CSR_PENDING, {exp_wr_pend, exp_rd_pend}, "CSR_PENDING");
        check_csr(CSR_STATUS, 32'h0, "CSR_STATUS after test");
        check_value("number of host writes", wr_q.size(), n_writes);
        if (errors == errors_before)
            $display("test %0d passed", id);
        else
        begin
            tests_failed++;
            $display("test %0d failed", id);
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial
    begin
        test_rst_n   = 1'b0;
        csr_wr       = 1'b0;
        csr_rd       = 1'b0;
        csr_addr     = '0;
        csr_wdata    = '0;
        eng_done     = '0;
        mon          = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        stalls_left  = 0;
        aborted      = 1'b0;
        exp_reads    = '0;
        exp_writes   = '0;
        exp_rd_pend  = '0;
        exp_wr_pend  = '0;
        exp_uid      = '0;
        for (int i = 0; i < STIM_COLS * MAX_TESTS; i++)
            stim_mem[i] = '0;
        $readmemh("tests/lb_stim.txt", stim_mem);

        repeat (8) @(negedge clk);
        test_rst_n = 1'b1;
        @(negedge clk);

        csr_access_test();
        // A zero id ends the list
        for (int t = 0; (t < MAX_TESTS) && (stim_mem[t*STIM_COLS] != 0) && !aborted; t++)
            run_test(t);

        // Bound protocol checks count toward the verdict
        if (lb_exerciser_top_inst.lb_exerciser_assertions_inst.fail_count != 0)
        begin
            $display("bound assertions failed %0d times",
                     lb_exerciser_top_inst.lb_exerciser_assertions_inst.fail_count);
            errors = errors + lb_exerciser_top_inst.lb_exerciser_assertions_inst.fail_count;
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if ((errors == 0) && (tests_failed == 0) && (tests_run > 1))
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
design/lb_pkg.sv
design/lb_csr_regs.sv
design/lb_test_sequencer.sv
design/lb_status_writer.sv
design/lb_traffic_stats.sv
design/lb_exerciser_top.sv
tests/lb_exerciser_assertions.sv
tests/tb_lb_exerciser.sv
